// File: filelist.f
verilog/l1_cache_pkg.sv
verilog/miss_req_if.sv
verilog/cache_tag_mem.sv
verilog/cache_lru.sv
verilog/load_miss_queue.sv
verilog/l1_cache.sv
verilog/l1_cache_top.sv
verification/l1_cache_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = l1_cache_tb
FILELIST = filelist.f
LOG      = sim.log

.PHONY: compile run clean

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verification/l1_cache_tb.sv
////////////////////
// Random testbench for the L1 cache with a reactive L2 model.
// Line data is a fixed function of the line address.
// Random sets stay in 0..3; set 9 is kept for the LRU eviction run.
////////////////////

`timescale 1ns/1ps
`default_nettype none

module l1_cache_tb;

	localparam logic [1:0] UNIT = 2'd1;
	localparam int NUM_ACC = 2000;
	// Four queued strands, each up to four cycles to ack and four to answer
	localparam int WORST_MISS = 40;
	localparam int TIMEOUT_NS = (NUM_ACC + 20) * WORST_MISS * 4;

	logic clk, rst_i, access_i, pci_ack_i, cpi_valid_i;
	logic [31:0] address_i;
	logic [1:0] strand_i, cpi_unit_i, cpi_strand_i, cpi_way_i;
	logic [511:0] cpi_data_i, data_o;
	logic cache_hit_o, load_collision_o, pci_valid_o;
	logic [3:0] load_complete_o;
	logic [1:0] pci_unit_o, pci_strand_o, pci_way_o;
	l1_cache_pkg::l2_op_t pci_op_o;
	logic [25:0] pci_address_o;

	// Reference state of the cache and the miss entries
	logic [20:0] m_tag [32][4];
	bit m_valid [32][4];
	int m_age [32][4];
	int m_state [4];
	logic [25:0] exp_line [4];
	int exp_way [4];
	bit busy [4];

	// Pending L2 responses, in ack order
	logic [1:0] rq_strand [$];
	logic [1:0] rq_way [$];
	logic [25:0] rq_line [$];
	int rq_delay [$];
	int ack_delay = 0;
	bit valid_seen, soon_v, acc_v, pf_v;
	logic [25:0] soon_line, pf_line;
	logic [31:0] acc_addr;
	logic [1:0] acc_strand;
	int pf_way;

	l1_cache_top #(.UNIT_ID(UNIT)) l1_cache_top_inst (.*);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [511:0] line_data(input logic [25:0] line);
		logic [511:0] d;
		for (int i = 0; i < 16; i++)
			d[i*32 +: 32] = {line, 6'(i)} * 32'h9E3779B1;
		return d;
	endfunction

	function automatic logic [31:0] random_addr();
		return {21'h1000 + 21'($urandom % 6), 5'($urandom % 4), 6'($urandom)};
	endfunction

	task automatic check_value(input string name, input logic [511:0] got,
		input logic [511:0] exp);
		if (got !== exp)
		begin
			$display("Fail %s: got %0h expected %0h", name, got, exp);
			$display("Regression failed");
			$fatal(1);
		end
	endtask

	// The touched way becomes newest and only newer ways age
	task automatic touch_lru(input int set, input int way);
		int a;
		a = m_age[set][way];
		for (int w = 0; w < 4; w++)
			if (w == way)
				m_age[set][w] = 0;
			else if (m_age[set][w] < a)
				m_age[set][w]++;
	endtask

	task automatic access_and_wait(input logic [1:0] s, input logic [31:0] addr);
		@(posedge clk);
		access_i <= 1'b1;
		address_i <= addr;
		strand_i <= s;
		busy[s] = 1'b1;
		@(posedge clk);
		access_i <= 1'b0;
		while (busy[s])
			@(posedge clk);
	endtask

	// Outputs are stable at the falling edge, half a cycle after the inputs moved
	always @(negedge clk)
	begin : monitor
		bit fill_now, hit, coll;
		logic [1:0] fs;
		logic [25:0] fl, line;
		int fw, hw, vic, set;
		if (!rst_i)
		begin
			if (pci_valid_o)
			begin
				check_value("pci_valid_o entry", 512'(m_state[pci_strand_o]), 512'(1));
				check_value("pci_address_o", 512'(pci_address_o),
					512'(exp_line[pci_strand_o]));
				check_value("pci_way_o", 512'(pci_way_o), 512'(exp_way[pci_strand_o]));
				check_value("pci_unit_o", 512'(pci_unit_o), 512'(UNIT));
				check_value("pci_op_o", 512'(pci_op_o), 512'(l1_cache_pkg::L2_OP_LOAD));
				if (pci_ack_i)
				begin
					m_state[pci_strand_o] = 2;
					rq_strand.push_back(pci_strand_o);
					rq_way.push_back(pci_way_o);
					rq_line.push_back(pci_address_o);
					rq_delay.push_back(int'($urandom % 4));
				end
			end
			valid_seen = pci_valid_o && !pci_ack_i;
			// Foreign unit responses must leave everything unchanged
			fill_now = cpi_valid_i && cpi_unit_i == UNIT;
			fs = cpi_strand_i;
			fl = exp_line[fs];
			fw = exp_way[fs];
			check_value("load_complete_o", 512'(load_complete_o),
				512'(fill_now ? 4'b1 << fs : 4'b0));
			if (fill_now)
			begin
				check_value("response entry", 512'(m_state[fs]), 512'(2));
				m_state[fs] = 0;
				busy[fs] = 1'b0;
			end
			line = acc_addr[31:6];
			set = int'(acc_addr[10:6]);
			coll = acc_v && ((pf_v && pf_line == line) || (fill_now && fl == line));
			hit = 1'b0;
			hw = 0;
			vic = 0;
			for (int w = 0; w < 4; w++)
			begin
				if (m_valid[set][w] && m_tag[set][w] == acc_addr[31:11])
				begin
					hit = 1'b1;
					hw = w;
				end
				if (m_age[set][w] == 3)
					vic = w;
			end
			check_value("load_collision_o", 512'(load_collision_o), 512'(coll));
			check_value("cache_hit_o", 512'(cache_hit_o), 512'(acc_v && hit && !coll));
			if (acc_v && hit && !coll)
				check_value("data_o", data_o, line_data(line));
			if (acc_v && !coll)
				touch_lru(set, hit ? hw : vic);
			if (acc_v && !coll && !hit)
			begin
				m_state[acc_strand] = 1;
				exp_line[acc_strand] = line;
				exp_way[acc_strand] = vic;
			end
			else if (acc_v)
				busy[acc_strand] = 1'b0;
			// A fill is written at the end of its cycle, seen two lookups later
			if (pf_v)
			begin
				m_tag[pf_line[4:0]][pf_way] = pf_line[25:5];
				m_valid[pf_line[4:0]][pf_way] = 1'b1;
			end
			pf_v = fill_now;
			pf_line = fl;
			pf_way = fw;
			soon_v = rq_delay.size() > 0 && rq_delay[0] <= 1;
			soon_line = rq_line.size() > 0 ? rq_line[0] : '0;
			acc_v = access_i;
			acc_addr = address_i;
			acc_strand = strand_i;
		end
	end

	// L2 model with random ack delay, response delay and foreign traffic
	always @(posedge clk)
	begin
		if (!rst_i)
		begin
			cpi_valid_i <= 1'b0;
			if (pci_ack_i)
			begin
				pci_ack_i <= 1'b0;
				ack_delay = int'($urandom % 4);
			end
			else if (valid_seen)
			begin
				if (ack_delay == 0)
					pci_ack_i <= 1'b1;
				else
					ack_delay--;
			end
			if (rq_delay.size() > 0 && rq_delay[0] == 0)
			begin
				cpi_valid_i <= 1'b1;
				cpi_unit_i <= UNIT;
				cpi_strand_i <= rq_strand.pop_front();
				cpi_way_i <= rq_way.pop_front();
				cpi_data_i <= line_data(rq_line.pop_front());
				void'(rq_delay.pop_front());
			end
			else
			begin
				if (rq_delay.size() > 0)
					rq_delay[0]--;
				// Another unit's response, aimed at a pending entry when there is one
				if ($urandom % 16 == 0)
				begin
					cpi_valid_i <= 1'b1;
					cpi_unit_i <= 2'(UNIT + 2'd1 + 2'($urandom % 3));
					cpi_strand_i <= rq_strand.size() > 0 ? rq_strand[0] : 2'($urandom);
					cpi_way_i <= rq_way.size() > 0 ? rq_way[0] : 2'($urandom);
					cpi_data_i <= {16{$urandom}};
				end
			end
		end
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout: the cache or the L2 model stopped making progress");
		$display("Regression failed");
		$fatal(1);
	end

	initial
	begin
		logic [1:0] s;
		logic [31:0] addr;
		void'($urandom(48));
		rst_i = 1'b1;
		access_i = 1'b0;
		address_i = '0;
		strand_i = '0;
		pci_ack_i = 1'b0;
		cpi_valid_i = 1'b0;
		cpi_unit_i = '0;
		cpi_strand_i = '0;
		cpi_way_i = '0;
		cpi_data_i = '0;
		for (int i = 0; i < 32; i++)
			for (int w = 0; w < 4; w++)
			begin
				m_valid[i][w] = 1'b0;
				m_age[i][w] = w;
			end
		for (int i = 0; i < 4; i++)
		begin
			m_state[i] = 0;
			busy[i] = 1'b0;
		end
		repeat (7) @(posedge clk);
		@(negedge clk);
		check_value("pci_valid_o", 512'(pci_valid_o), 512'(0));
		check_value("cache_hit_o", 512'(cache_hit_o), 512'(0));
		check_value("load_collision_o", 512'(load_collision_o), 512'(0));
		check_value("load_complete_o", 512'(load_complete_o), 512'(0));
		@(posedge clk);
		rst_i <= 1'b0;
		repeat (NUM_ACC)
		begin
			@(posedge clk);
			s = 2'($urandom % 4);
			addr = random_addr();
			// Aim at a line about to be filled to provoke collisions
			if (soon_v && $urandom % 3 == 0)
				addr = {soon_line, 6'($urandom)};
			if (!busy[s] && $urandom % 4 != 0)
			begin
				access_i <= 1'b1;
				address_i <= addr;
				strand_i <= s;
				busy[s] = 1'b1;
			end
			else
				access_i <= 1'b0;
		end
		@(posedge clk);
		access_i <= 1'b0;
		while (busy[0] || busy[1] || busy[2] || busy[3])
			@(posedge clk);
		// Five tags in set 9, then the newest four and the first, which was evicted
		for (int r = 0; r < 2; r++)
			for (int t = 0; t < 5; t++)
				access_and_wait(2'd0, {21'h2000 + 21'((t + r) % 5), 5'd9, 6'd0});
		repeat (4) @(posedge clk);
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/l1_cache_top.sv
////////////////////
// L1 cache with its L2 port as plain signals.
// UNIT_ID tells this cache's traffic apart on a shared L2.
// A strand must not access again until its load_complete_o bit pulses.
////////////////////

`timescale 1ns/1ps
`default_nettype none

module l1_cache_top #(
	parameter logic [1:0] UNIT_ID = 2'd0
) (
	input  wire logic                                   clk,
	input  wire logic                                   rst_i,
	input  wire logic [31:0]                            address_i,
	input  wire logic [l1_cache_pkg::STRAND_WIDTH-1:0]  strand_i,
	input  wire logic                                   access_i,
	output logic [l1_cache_pkg::LINE_WIDTH-1:0]         data_o,
	output logic                                        cache_hit_o,
	output logic                                        load_collision_o,
	output logic [l1_cache_pkg::NUM_STRANDS-1:0]        load_complete_o,
	output logic                                        pci_valid_o,
	input  wire logic                                   pci_ack_i,
	output logic [1:0]                                  pci_unit_o,
	output logic [l1_cache_pkg::STRAND_WIDTH-1:0]       pci_strand_o,
	output l1_cache_pkg::l2_op_t                        pci_op_o,
	output logic [l1_cache_pkg::WAY_WIDTH-1:0]          pci_way_o,
	output logic [l1_cache_pkg::L2_ADDR_WIDTH-1:0]      pci_address_o,
	input  wire logic                                   cpi_valid_i,
	input  wire logic [1:0]                             cpi_unit_i,
	input  wire logic [l1_cache_pkg::STRAND_WIDTH-1:0]  cpi_strand_i,
	input  wire logic [l1_cache_pkg::WAY_WIDTH-1:0]     cpi_way_i,
	input  wire logic [l1_cache_pkg::LINE_WIDTH-1:0]    cpi_data_i
);

	miss_req_if mq_bus ();

	l1_cache #(.UNIT_ID(UNIT_ID)) l1_cache_inst (
		.clk              (clk),
		.rst_i            (rst_i),
		.address_i        (address_i),
		.strand_i         (strand_i),
		.access_i         (access_i),
		.data_o           (data_o),
		.cache_hit_o      (cache_hit_o),
		.load_collision_o (load_collision_o),
		.cpi_valid_i      (cpi_valid_i),
		.cpi_unit_i       (cpi_unit_i),
		.cpi_data_i       (cpi_data_i),
		.mq               (mq_bus.core)
	);

	load_miss_queue #(.UNIT_ID(UNIT_ID)) load_miss_queue_inst (
		.clk           (clk),
		.rst_i         (rst_i),
		.mq            (mq_bus.queue),
		.pci_valid_o   (pci_valid_o),
		.pci_ack_i     (pci_ack_i),
		.pci_unit_o    (pci_unit_o),
		.pci_strand_o  (pci_strand_o),
		.pci_op_o      (pci_op_o),
		.pci_way_o     (pci_way_o),
		.pci_address_o (pci_address_o),
		.cpi_valid_i   (cpi_valid_i),
		.cpi_unit_i    (cpi_unit_i),
		.cpi_strand_i  (cpi_strand_i),
		.cpi_way_i     (cpi_way_i)
	);

	// Completion mask is the fill's strand mask, live in the response cycle
	assign load_complete_o = mq_bus.fill_strands;

endmodule

`default_nettype wire

// File: verilog/l1_cache.sv
////////////////////
// Cache core: one-cycle lookup over four data ways, read-only.
// A miss is handed to the miss queue with the LRU victim way.
// An access meeting a fill of its own line reports a collision,
// neither hits nor queues, and must be retried by the core.
////////////////////

`timescale 1ns/1ps
`default_nettype none

module l1_cache #(
	parameter logic [1:0] UNIT_ID = 2'd0
) (
	input  wire logic                                   clk,
	input  wire logic                                   rst_i,
	input  wire logic [31:0]                            address_i,
	input  wire logic [l1_cache_pkg::STRAND_WIDTH-1:0]  strand_i,
	input  wire logic                                   access_i,
	output logic [l1_cache_pkg::LINE_WIDTH-1:0]         data_o,
	output logic                                        cache_hit_o,
	output logic                                        load_collision_o,
	input  wire logic                                   cpi_valid_i,
	input  wire logic [1:0]                             cpi_unit_i,
	input  wire logic [l1_cache_pkg::LINE_WIDTH-1:0]    cpi_data_i,
	miss_req_if.core                                    mq
);

	logic [l1_cache_pkg::LINE_WIDTH-1:0] way_data [l1_cache_pkg::NUM_WAYS][l1_cache_pkg::NUM_SETS];
	logic [l1_cache_pkg::LINE_WIDTH-1:0] way_rd [l1_cache_pkg::NUM_WAYS];
	logic [l1_cache_pkg::SET_WIDTH-1:0]  request_set;
	logic [l1_cache_pkg::TAG_WIDTH-1:0]  request_tag;
	logic [l1_cache_pkg::STRAND_WIDTH-1:0] strand_latched;
	logic                                access_latched;
	logic [l1_cache_pkg::WAY_WIDTH-1:0]  hit_way;
	logic [l1_cache_pkg::WAY_WIDTH-1:0]  lru_way;
	logic                                tag_hit;
	logic                                fill_write;
	logic                                collision_early;
	logic                                collision_late;

	cache_tag_mem tag_mem_inst (
		.clk          (clk),
		.rst_i        (rst_i),
		.access_i     (access_i),
		.address_i    (address_i),
		.update_i     (mq.fill_valid),
		.update_way_i (mq.fill_way),
		.update_tag_i (mq.fill_tag),
		.update_set_i (mq.fill_set),
		.hit_way_o    (hit_way),
		.cache_hit_o  (tag_hit)
	);

	// Victim lookup and MRU update use the set of the access being resolved
	cache_lru lru_inst (
		.clk           (clk),
		.rst_i         (rst_i),
		.set_i         (request_set),
		.update_mru_i  (access_latched && !load_collision_o),
		.new_mru_way_i (tag_hit ? hit_way : lru_way),
		.lru_way_o     (lru_way)
	);

	// Payload of the lookup stage; all four ways are read in parallel
	always_ff @(posedge clk)
	begin
		for (int w = 0; w < l1_cache_pkg::NUM_WAYS; w++)
			way_rd[w] <= way_data[w][address_i[10:6]];
		request_set <= address_i[10:6];
		request_tag <= address_i[31:11];
		strand_latched <= strand_i;
	end

	assign data_o = way_rd[hit_way];

	// Only this unit's response strobe may write the line
	assign fill_write = cpi_valid_i && cpi_unit_i == UNIT_ID && mq.fill_valid;

	always_ff @(posedge clk)
	begin
		if (fill_write)
			way_data[mq.fill_way][mq.fill_set] <= cpi_data_i;
	end

	// Fill in the access cycle: the tag read missed the new line
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			access_latched <= 1'b0;
			collision_early <= 1'b0;
		end
		else
		begin
			access_latched <= access_i;
			collision_early <= access_i && mq.fill_valid
				&& mq.fill_tag == address_i[31:11] && mq.fill_set == address_i[10:6];
		end
	end

	// Fill in the cycle after: a miss now would load the line twice
	assign collision_late = access_latched && mq.fill_valid
		&& mq.fill_tag == request_tag && mq.fill_set == request_set;

	assign load_collision_o = collision_early || collision_late;
	assign cache_hit_o = tag_hit && !load_collision_o;

	assign mq.req = access_latched && !tag_hit && !load_collision_o;
	assign mq.req_strand = strand_latched;
	assign mq.req_tag = request_tag;
	assign mq.req_set = request_set;
	assign mq.req_way = lru_way;

endmodule

`default_nettype wire

// File: verilog/load_miss_queue.sv
////////////////////
// One miss entry per strand; a strand never has two misses in flight.
// One request sits on the L2 port at a time, picked round-robin.
// A response is taken only after its request was acked.
////////////////////

`timescale 1ns/1ps
`default_nettype none

module load_miss_queue #(
	parameter logic [1:0] UNIT_ID = 2'd0
) (
	input  wire logic                                   clk,
	input  wire logic                                   rst_i,
	miss_req_if.queue                                   mq,
	output logic                                        pci_valid_o,
	input  wire logic                                   pci_ack_i,
	output logic [1:0]                                  pci_unit_o,
	output logic [l1_cache_pkg::STRAND_WIDTH-1:0]       pci_strand_o,
	output l1_cache_pkg::l2_op_t                        pci_op_o,
	output logic [l1_cache_pkg::WAY_WIDTH-1:0]          pci_way_o,
	output logic [l1_cache_pkg::L2_ADDR_WIDTH-1:0]      pci_address_o,
	input  wire logic                                   cpi_valid_i,
	input  wire logic [1:0]                             cpi_unit_i,
	input  wire logic [l1_cache_pkg::STRAND_WIDTH-1:0]  cpi_strand_i,
	input  wire logic [l1_cache_pkg::WAY_WIDTH-1:0]     cpi_way_i
);

	l1_cache_pkg::mq_state_t            entry_state [l1_cache_pkg::NUM_STRANDS];
	logic [l1_cache_pkg::TAG_WIDTH-1:0] entry_tag [l1_cache_pkg::NUM_STRANDS];
	logic [l1_cache_pkg::SET_WIDTH-1:0] entry_set [l1_cache_pkg::NUM_STRANDS];
	logic [l1_cache_pkg::WAY_WIDTH-1:0] entry_way [l1_cache_pkg::NUM_STRANDS];
	logic                               issue_active;
	logic [l1_cache_pkg::STRAND_WIDTH-1:0] issue_strand;
	logic [l1_cache_pkg::STRAND_WIDTH-1:0] pick_strand;
	logic                               pick_found;
	logic                               resp_match;

	// Search from the strand after the last one issued, wrapping round
	always_comb
	begin
		logic [l1_cache_pkg::STRAND_WIDTH-1:0] cand;
		pick_found = 1'b0;
		pick_strand = '0;
		for (int i = 1; i <= l1_cache_pkg::NUM_STRANDS; i++)
		begin
			cand = issue_strand + i[l1_cache_pkg::STRAND_WIDTH-1:0];
			if (!pick_found && entry_state[cand] == l1_cache_pkg::MQ_WAIT_ISSUE)
			begin
				pick_found = 1'b1;
				pick_strand = cand;
			end
		end
	end

	// The L2 echoes the way it was asked to fill
	assign resp_match = cpi_valid_i && cpi_unit_i == UNIT_ID
		&& entry_state[cpi_strand_i] == l1_cache_pkg::MQ_WAIT_RESP
		&& cpi_way_i == entry_way[cpi_strand_i];

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			issue_active <= 1'b0;
			issue_strand <= '0;
			for (int s = 0; s < l1_cache_pkg::NUM_STRANDS; s++)
				entry_state[s] <= l1_cache_pkg::MQ_IDLE;
		end
		else
		begin
			if (mq.req)
				entry_state[mq.req_strand] <= l1_cache_pkg::MQ_WAIT_ISSUE;
			// Request holds on the port until acked, then the next can start
			if (issue_active && pci_ack_i)
			begin
				issue_active <= 1'b0;
				entry_state[issue_strand] <= l1_cache_pkg::MQ_WAIT_RESP;
			end
			else if (!issue_active && pick_found)
			begin
				issue_active <= 1'b1;
				issue_strand <= pick_strand;
			end
			if (resp_match)
				entry_state[cpi_strand_i] <= l1_cache_pkg::MQ_IDLE;
		end
	end

	always_ff @(posedge clk)
	begin
		if (mq.req)
		begin
			entry_tag[mq.req_strand] <= mq.req_tag;
			entry_set[mq.req_strand] <= mq.req_set;
			entry_way[mq.req_strand] <= mq.req_way;
		end
	end

	assign pci_valid_o = issue_active;
	assign pci_unit_o = UNIT_ID;
	assign pci_strand_o = issue_strand;
	assign pci_op_o = l1_cache_pkg::L2_OP_LOAD;
	assign pci_way_o = entry_way[issue_strand];
	assign pci_address_o = {entry_tag[issue_strand], entry_set[issue_strand]};

	// Fill info comes from the entry, visible in the response cycle itself
	assign mq.fill_valid = resp_match;
	assign mq.fill_way = entry_way[cpi_strand_i];
	assign mq.fill_tag = entry_tag[cpi_strand_i];
	assign mq.fill_set = entry_set[cpi_strand_i];
	assign mq.fill_strands = resp_match ? l1_cache_pkg::NUM_STRANDS'(1) << cpi_strand_i : '0;

endmodule

`default_nettype wire

// File: verilog/cache_lru.sv
////////////////////
// True LRU by age: a 2-bit age per way per set, 0 is newest.
// lru_way_o is combinational on set_i.
////////////////////

`timescale 1ns/1ps
`default_nettype none

module cache_lru (
	input  wire logic                                 clk,
	input  wire logic                                 rst_i,
	input  wire logic [l1_cache_pkg::SET_WIDTH-1:0]   set_i,
	input  wire logic                                 update_mru_i,
	input  wire logic [l1_cache_pkg::WAY_WIDTH-1:0]   new_mru_way_i,
	output logic [l1_cache_pkg::WAY_WIDTH-1:0]        lru_way_o
);

	logic [l1_cache_pkg::WAY_WIDTH-1:0] age [l1_cache_pkg::NUM_SETS][l1_cache_pkg::NUM_WAYS];

	// The oldest way always has the top age, as ages stay a permutation
	always_comb
	begin
		lru_way_o = '0;
		for (int w = 0; w < l1_cache_pkg::NUM_WAYS; w++)
			if (age[set_i][w] == l1_cache_pkg::WAY_WIDTH'(l1_cache_pkg::NUM_WAYS - 1))
				lru_way_o = w[l1_cache_pkg::WAY_WIDTH-1:0];
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			// Start with way 3 as the first victim of every set
			for (int s = 0; s < l1_cache_pkg::NUM_SETS; s++)
				for (int w = 0; w < l1_cache_pkg::NUM_WAYS; w++)
					age[s][w] <= w[l1_cache_pkg::WAY_WIDTH-1:0];
		end
		else if (update_mru_i)
		begin
			// Only ways newer than the touched one grow older
			for (int w = 0; w < l1_cache_pkg::NUM_WAYS; w++)
			begin
				if (w == new_mru_way_i)
					age[set_i][w] <= '0;
				else if (age[set_i][w] < age[set_i][new_mru_way_i])
					age[set_i][w] <= age[set_i][w] + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/cache_tag_mem.sv
////////////////////
// Tag and valid arrays for four ways.
// Lookup result appears one cycle after access_i.
// A fill written at the same edge as a lookup is not seen by that lookup.
////////////////////

`timescale 1ns/1ps
`default_nettype none

module cache_tag_mem (
	input  wire logic                                 clk,
	input  wire logic                                 rst_i,
	input  wire logic                                 access_i,
	input  wire logic [31:0]                          address_i,
	input  wire logic                                 update_i,
	input  wire logic [l1_cache_pkg::WAY_WIDTH-1:0]   update_way_i,
	input  wire logic [l1_cache_pkg::TAG_WIDTH-1:0]   update_tag_i,
	input  wire logic [l1_cache_pkg::SET_WIDTH-1:0]   update_set_i,
	output logic [l1_cache_pkg::WAY_WIDTH-1:0]        hit_way_o,
	output logic                                      cache_hit_o
);

	logic [l1_cache_pkg::TAG_WIDTH-1:0] tags [l1_cache_pkg::NUM_WAYS][l1_cache_pkg::NUM_SETS];
	logic [l1_cache_pkg::NUM_SETS-1:0]  valid [l1_cache_pkg::NUM_WAYS];
	logic [l1_cache_pkg::TAG_WIDTH-1:0] tag_rd [l1_cache_pkg::NUM_WAYS];
	logic [l1_cache_pkg::NUM_WAYS-1:0]  valid_rd;
	logic [l1_cache_pkg::TAG_WIDTH-1:0] request_tag;
	logic                               access_latched;
	logic [l1_cache_pkg::NUM_WAYS-1:0]  way_match;

	// Read every way of the addressed set at once
	always_ff @(posedge clk)
	begin
		for (int w = 0; w < l1_cache_pkg::NUM_WAYS; w++)
		begin
			tag_rd[w] <= tags[w][address_i[10:6]];
			valid_rd[w] <= valid[w][address_i[10:6]];
		end
		request_tag <= address_i[31:11];
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			access_latched <= 1'b0;
			for (int w = 0; w < l1_cache_pkg::NUM_WAYS; w++)
				valid[w] <= '0;
		end
		else
		begin
			access_latched <= access_i;
			// A fill marks its way valid; nothing clears a line afterwards
			if (update_i)
				valid[update_way_i][update_set_i] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (update_i)
			tags[update_way_i][update_set_i] <= update_tag_i;
	end

	// Compare in the cycle after the read and encode the matching way
	always_comb
	begin
		hit_way_o = '0;
		for (int w = 0; w < l1_cache_pkg::NUM_WAYS; w++)
		begin
			way_match[w] = valid_rd[w] && tag_rd[w] == request_tag;
			if (way_match[w])
				hit_way_o = w[l1_cache_pkg::WAY_WIDTH-1:0];
		end
	end

	assign cache_hit_o = access_latched && |way_match;

endmodule

`default_nettype wire

// File: verilog/miss_req_if.sv
////////////////////
// Miss request from the cache core and fill back from the miss queue.
// req is a one-cycle strobe; fill_* are valid while fill_valid is high.
////////////////////

`timescale 1ns/1ps
`default_nettype none

interface miss_req_if;

	// Core to queue
	logic                                   req;
	logic [l1_cache_pkg::STRAND_WIDTH-1:0]  req_strand;
	logic [l1_cache_pkg::TAG_WIDTH-1:0]     req_tag;
	logic [l1_cache_pkg::SET_WIDTH-1:0]     req_set;
	logic [l1_cache_pkg::WAY_WIDTH-1:0]     req_way;

	// Queue to core, one-hot strand mask included
	logic                                   fill_valid;
	logic [l1_cache_pkg::WAY_WIDTH-1:0]     fill_way;
	logic [l1_cache_pkg::TAG_WIDTH-1:0]     fill_tag;
	logic [l1_cache_pkg::SET_WIDTH-1:0]     fill_set;
	logic [l1_cache_pkg::NUM_STRANDS-1:0]   fill_strands;

	modport core (output req, req_strand, req_tag, req_set, req_way,
		input fill_valid, fill_way, fill_tag, fill_set, fill_strands);
	modport queue (input req, req_strand, req_tag, req_set, req_way,
		output fill_valid, fill_way, fill_tag, fill_set, fill_strands);

endinterface

`default_nettype wire

// File: verilog/l1_cache_pkg.sv
////////////////////
// Shared geometry and encodings of the L1 cache.
// Line addresses are 32 bits: offset 5..0, set 10..6, tag 31..11.
// Only the load opcode toward the L2 is implemented.
////////////////////

`default_nettype none

package l1_cache_pkg;

	// Four ways of 32 sets of 64-byte lines
	localparam int NUM_WAYS = 4;
	localparam int NUM_STRANDS = 4;
	localparam int SET_WIDTH = 5;
	localparam int NUM_SETS = 32;
	localparam int TAG_WIDTH = 21;
	localparam int LINE_WIDTH = 512;

	// Index widths derived from the counts above
	localparam int WAY_WIDTH = $clog2(NUM_WAYS);
	localparam int STRAND_WIDTH = $clog2(NUM_STRANDS);

	// The L2 is addressed by line, so tag and set together
	localparam int L2_ADDR_WIDTH = TAG_WIDTH + SET_WIDTH;

	// Request opcodes on the L2 port, which is 3 bits wide
	typedef enum logic [2:0] {
		L2_OP_LOAD = 3'd0
	} l2_op_t;

	// Life of one per-strand miss entry
	typedef enum logic [1:0] {
		MQ_IDLE,
		MQ_WAIT_ISSUE,
		MQ_WAIT_RESP
	} mq_state_t;

endpackage

`default_nettype wire
